//--- source/mm_pkg.sv
package mm_pkg;

  // Left operand width, row of A
  localparam int OP0_WIDTH = 16;

  // Top operand width, column of B
  localparam int OP1_WIDTH = 16;

  // Partial sum width
  // Sums wrap modulo 2^PSUM_WIDTH
  localparam int PSUM_WIDTH = 32;

  // Signed left operand
  typedef logic signed [OP0_WIDTH-1:0] op0_t;

  // Signed top operand
  typedef logic signed [OP1_WIDTH-1:0] op1_t;

  // Signed partial sum
  typedef logic signed [PSUM_WIDTH-1:0] psum_t;

endpackage

//--- source/axis_skid_buffer.sv
`timescale 1ns/10ps

module axis_skid_buffer #(
  parameter int DATA_WIDTH = 16
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [DATA_WIDTH-1:0] in_data,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic                  in_last,
  output logic [DATA_WIDTH-1:0] out_data,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic                  out_last
);

  // Two entries, each holds last above data
  logic [DATA_WIDTH:0] mem [2];
  logic                wr_ptr;
  logic                rd_ptr;
  logic [1:0]          count;
  logic                push;
  logic                pop;

  // Room for a word unless both entries are taken
  assign in_ready  = (count != 2'd2);
  assign out_valid = (count != 2'd0);

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  // Oldest word always on the output
  assign {out_last, out_data} = mem[rd_ptr];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      // Simultaneous push and pop keeps the fill level
      if (push && !pop) begin
        count <= count + 2'd1;
      end else if (pop && !push) begin
        count <= count - 2'd1;
      end
    end
  end

  // Storage only, valid comes from count
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {in_last, in_data};
    end
  end

endmodule

//--- source/pe_control.sv
`timescale 1ns/10ps

module pe_control #(
  parameter int PE_POSITION_J = 0
) (
  input  logic clk,
  input  logic arst_n,
  // Buffered left and top operand heads
  input  logic l_valid,
  input  logic l_last,
  input  logic t_valid,
  input  logic t_last,
  // Readiness of right and bottom consumers
  input  logic r_ready,
  input  logic b_ready,
  // Buffered up stream head
  input  logic u_valid,
  input  logic u_last,
  // Readiness of down consumer
  input  logic d_ready,
  output logic consume,
  output logic first,
  output logic forward_up,
  output logic export_result,
  output logic err_unaligned_data
);

  // Phase encoding
  localparam logic [1:0] ST_ACC = 2'd0;
  localparam logic [1:0] ST_FWD = 2'd1;
  localparam logic [1:0] ST_EXP = 2'd2;

  // PE 0 has nothing above it to forward
  localparam bit HAS_UP = (PE_POSITION_J > 0);

  logic [1:0] state;
  logic       fwd_done;
  logic       pair_last;

  // Pair taken only when both heads present and both outputs free
  assign consume = (state == ST_ACC) & l_valid & t_valid & r_ready & b_ready;

  // Left stream decides the end of a vector
  assign pair_last = consume & l_last;

  assign forward_up    = (state == ST_FWD);
  assign export_result = (state == ST_EXP);

  // Final word from above handed on
  assign fwd_done = HAS_UP & forward_up & u_valid & u_last & d_ready;

  // Phase register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_ACC;
    end else begin
      case (state)
        ST_ACC: begin
          if (pair_last) begin
            state <= HAS_UP ? ST_FWD : ST_EXP;
          end
        end
        ST_FWD: begin
          if (fwd_done) begin
            state <= ST_EXP;
          end
        end
        ST_EXP: begin
          // Own result accepted downstream
          if (d_ready) begin
            state <= ST_ACC;
          end
        end
        default: begin
          state <= ST_ACC;
        end
      endcase
    end
  end

  // First-of-vector flag
  // Set again once a vector closes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      first <= 1'b1;
    end else if (consume) begin
      first <= l_last;
    end
  end

  // Sticky mismatch of last flags, cleared by reset only
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      err_unaligned_data <= 1'b0;
    end else if (consume && (l_last != t_last)) begin
      err_unaligned_data <= 1'b1;
    end
  end

endmodule

//--- source/pe_mac.sv
`timescale 1ns/10ps

module pe_mac (
  input  logic         clk,
  input  logic         arst_n,
  input  logic         consume,
  input  logic         first,
  input  mm_pkg::op0_t op0,
  input  mm_pkg::op1_t op1,
  output mm_pkg::psum_t acc
);

  import mm_pkg::*;

  // Full precision signed product
  logic signed [OP0_WIDTH+OP1_WIDTH-1:0] prod;
  psum_t                                 prod_ext;

  assign prod = op0 * op1;

  // Fit product to the sum width
  assign prod_ext = psum_t'(prod);

  // Accumulator register
  // First pair of a vector overwrites the old sum
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc <= '0;
    end else if (consume) begin
      if (first) begin
        acc <= prod_ext;
      end else begin
        // Wraps on overflow
        acc <= acc + prod_ext;
      end
    end
  end

endmodule

//--- source/linear_pe.sv
`timescale 1ns/10ps

module linear_pe #(
  parameter int PE_POSITION_J = 0
) (
  input  logic          clk,
  input  logic          arst_n,
  // Left in, right out
  input  mm_pkg::op0_t  l_data,
  input  logic          l_valid,
  output logic          l_ready,
  input  logic          l_last,
  output mm_pkg::op0_t  r_data,
  output logic          r_valid,
  input  logic          r_ready,
  output logic          r_last,
  // Top in, bottom out
  input  mm_pkg::op1_t  t_data,
  input  logic          t_valid,
  output logic          t_ready,
  input  logic          t_last,
  output mm_pkg::op1_t  b_data,
  output logic          b_valid,
  input  logic          b_ready,
  output logic          b_last,
  // Up in, down out
  input  mm_pkg::psum_t u_data,
  input  logic          u_valid,
  output logic          u_ready,
  input  logic          u_last,
  output mm_pkg::psum_t d_data,
  output logic          d_valid,
  input  logic          d_ready,
  output logic          d_last,
  output logic          err_unaligned_data
);

  import mm_pkg::*;

  // Buffered heads of the input streams
  op0_t  lb_data;
  logic  lb_valid;
  logic  lb_last;
  op1_t  tb_data;
  logic  tb_valid;
  logic  tb_last;
  psum_t ub_data;
  logic  ub_valid;
  logic  ub_ready;
  logic  ub_last;

  // Control outputs
  logic  consume;
  logic  first;
  logic  forward_up;
  logic  export_result;
  psum_t acc;

  // Left operand buffer
  axis_skid_buffer #(
    .DATA_WIDTH(OP0_WIDTH)
  ) i_l_buf (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_data  (l_data),
    .in_valid (l_valid),
    .in_ready (l_ready),
    .in_last  (l_last),
    .out_data (lb_data),
    .out_valid(lb_valid),
    .out_ready(consume),
    .out_last (lb_last)
  );

  // Top operand buffer
  axis_skid_buffer #(
    .DATA_WIDTH(OP1_WIDTH)
  ) i_t_buf (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_data  (t_data),
    .in_valid (t_valid),
    .in_ready (t_ready),
    .in_last  (t_last),
    .out_data (tb_data),
    .out_valid(tb_valid),
    .out_ready(consume),
    .out_last (tb_last)
  );

  if (PE_POSITION_J > 0) begin : g_up
    // Results from the PEs above
    axis_skid_buffer #(
      .DATA_WIDTH(PSUM_WIDTH)
    ) i_u_buf (
      .clk      (clk),
      .arst_n   (arst_n),
      .in_data  (u_data),
      .in_valid (u_valid),
      .in_ready (u_ready),
      .in_last  (u_last),
      .out_data (ub_data),
      .out_valid(ub_valid),
      .out_ready(ub_ready),
      .out_last (ub_last)
    );
  end else begin : g_no_up
    // Top row never takes from above
    assign u_ready  = 1'b0;
    assign ub_data  = '0;
    assign ub_valid = 1'b0;
    assign ub_last  = 1'b0;
  end

  pe_control #(
    .PE_POSITION_J(PE_POSITION_J)
  ) i_ctrl (
    .clk               (clk),
    .arst_n            (arst_n),
    .l_valid           (lb_valid),
    .l_last            (lb_last),
    .t_valid           (tb_valid),
    .t_last            (tb_last),
    .r_ready           (r_ready),
    .b_ready           (b_ready),
    .u_valid           (ub_valid),
    .u_last            (ub_last),
    .d_ready           (d_ready),
    .consume           (consume),
    .first             (first),
    .forward_up        (forward_up),
    .export_result     (export_result),
    .err_unaligned_data(err_unaligned_data)
  );

  pe_mac i_mac (
    .clk    (clk),
    .arst_n (arst_n),
    .consume(consume),
    .first  (first),
    .op0    (lb_data),
    .op1    (tb_data),
    .acc    (acc)
  );

  // Operands leave in the cycle they are consumed
  assign r_data  = lb_data;
  assign r_valid = consume;
  assign r_last  = lb_last;
  assign b_data  = tb_data;
  assign b_valid = consume;
  assign b_last  = tb_last;

  // Down mux, own result or words from above
  // Forwarded words lose last, only own export closes the round
  assign d_data   = export_result ? acc : ub_data;
  assign d_valid  = export_result | (forward_up & ub_valid);
  assign d_last   = export_result;
  assign ub_ready = forward_up & d_ready;

endmodule

//--- source/pe_column.sv
`timescale 1ns/10ps

module pe_column #(
  parameter int PE_NUMBER_J = 3
) (
  input  logic                           clk,
  input  logic                           arst_n,
  // One left stream per row
  input  mm_pkg::op0_t [PE_NUMBER_J-1:0] left_data,
  input  logic [PE_NUMBER_J-1:0]         left_valid,
  output logic [PE_NUMBER_J-1:0]         left_ready,
  input  logic [PE_NUMBER_J-1:0]         left_last,
  output mm_pkg::op0_t [PE_NUMBER_J-1:0] right_data,
  output logic [PE_NUMBER_J-1:0]         right_valid,
  input  logic [PE_NUMBER_J-1:0]         right_ready,
  output logic [PE_NUMBER_J-1:0]         right_last,
  // Column operand, enters at the top
  input  mm_pkg::op1_t                   top_data,
  input  logic                           top_valid,
  output logic                           top_ready,
  input  logic                           top_last,
  output mm_pkg::op1_t                   bottom_data,
  output logic                           bottom_valid,
  input  logic                           bottom_ready,
  output logic                           bottom_last,
  // Partial sums, row 0 first
  output mm_pkg::psum_t                  result_data,
  output logic                           result_valid,
  input  logic                           result_ready,
  output logic                           result_last,
  output logic                           err_unaligned_data
);

  import mm_pkg::*;

  // Vertical operand chain, index j enters PE j
  op1_t [PE_NUMBER_J:0]       v_data;
  logic [PE_NUMBER_J:0]       v_valid;
  logic [PE_NUMBER_J:0]       v_ready;
  logic [PE_NUMBER_J:0]       v_last;

  // Down streams leaving each PE
  psum_t [PE_NUMBER_J-1:0]    dn_data;
  logic [PE_NUMBER_J-1:0]     dn_valid;
  logic [PE_NUMBER_J-1:0]     dn_ready;
  logic [PE_NUMBER_J-1:0]     dn_last;

  // Up streams entering each PE
  psum_t [PE_NUMBER_J-1:0]    up_data;
  logic [PE_NUMBER_J-1:0]     up_valid;
  logic [PE_NUMBER_J-1:0]     up_ready;
  logic [PE_NUMBER_J-1:0]     up_last;

  logic [PE_NUMBER_J-1:0]     err_vec;

  // Column ends
  assign v_data[0]   = top_data;
  assign v_valid[0]  = top_valid;
  assign v_last[0]   = top_last;
  assign top_ready   = v_ready[0];
  assign bottom_data = v_data[PE_NUMBER_J];
  assign bottom_valid = v_valid[PE_NUMBER_J];
  assign bottom_last = v_last[PE_NUMBER_J];
  assign v_ready[PE_NUMBER_J] = bottom_ready;

  // Last PE drives the result stream
  assign result_data  = dn_data[PE_NUMBER_J-1];
  assign result_valid = dn_valid[PE_NUMBER_J-1];
  assign result_last  = dn_last[PE_NUMBER_J-1];
  assign dn_ready[PE_NUMBER_J-1] = result_ready;

  for (genvar j = 0; j < PE_NUMBER_J; j++) begin : g_pe
    if (j == 0) begin : g_head
      // Nothing above row 0
      assign up_data[j]  = '0;
      assign up_valid[j] = 1'b0;
      assign up_last[j]  = 1'b0;
    end else begin : g_link
      assign up_data[j]    = dn_data[j-1];
      assign up_valid[j]   = dn_valid[j-1];
      assign up_last[j]    = dn_last[j-1];
      assign dn_ready[j-1] = up_ready[j];
    end

    linear_pe #(
      .PE_POSITION_J(j)
    ) i_pe (
      .clk               (clk),
      .arst_n            (arst_n),
      .l_data            (left_data[j]),
      .l_valid           (left_valid[j]),
      .l_ready           (left_ready[j]),
      .l_last            (left_last[j]),
      .r_data            (right_data[j]),
      .r_valid           (right_valid[j]),
      .r_ready           (right_ready[j]),
      .r_last            (right_last[j]),
      .t_data            (v_data[j]),
      .t_valid           (v_valid[j]),
      .t_ready           (v_ready[j]),
      .t_last            (v_last[j]),
      .b_data            (v_data[j+1]),
      .b_valid           (v_valid[j+1]),
      .b_ready           (v_ready[j+1]),
      .b_last            (v_last[j+1]),
      .u_data            (up_data[j]),
      .u_valid           (up_valid[j]),
      .u_ready           (up_ready[j]),
      .u_last            (up_last[j]),
      .d_data            (dn_data[j]),
      .d_valid           (dn_valid[j]),
      .d_ready           (dn_ready[j]),
      .d_last            (dn_last[j]),
      .err_unaligned_data(err_vec[j])
    );
  end

  // Any row misaligned flags the column
  assign err_unaligned_data = |err_vec;

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int HALF_PERIOD = 4
) (
  output logic clk
);

  // Free running, 8 ns period
  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

//--- test/pe_column_sva.sv
`timescale 1ns/10ps

module pe_column_sva (
  input logic          clk,
  input logic          arst_n,
  input mm_pkg::psum_t result_data,
  input logic          result_valid,
  input logic          result_ready,
  input logic          result_last,
  input logic          err_unaligned_data
);

  // Failed assertion count seen by the testbench at the end
  int unsigned assert_fail_count = 0;

  // Result word held until taken
  a_result_hold: assert property (
    @(posedge clk) disable iff (!arst_n)
    (result_valid && !result_ready) |=>
      (result_valid && $stable(result_data) && $stable(result_last))
  ) else begin
    assert_fail_count++;
    $error("result stream changed while stalled");
  end

  // Sticky until reset
  a_err_sticky: assert property (
    @(posedge clk) disable iff (!arst_n)
    !$fell(err_unaligned_data)
  ) else begin
    assert_fail_count++;
    $error("err_unaligned_data fell without reset");
  end

endmodule

bind pe_column pe_column_sva i_sva (
  .clk               (clk),
  .arst_n            (arst_n),
  .result_data       (result_data),
  .result_valid      (result_valid),
  .result_ready      (result_ready),
  .result_last       (result_last),
  .err_unaligned_data(err_unaligned_data)
);

//--- test/tb_pe_column.sv
`timescale 1ns/10ps

module tb_pe_column;

  import mm_pkg::*;

  localparam int NJ            = 3;
  localparam int MAX_K         = 8;
  localparam int RANDOM_ROUNDS = 200;
  localparam int ROUND_TIMEOUT = 2000;
  localparam int ERR_TIMEOUT   = 200;
  localparam int ERR_ROW       = 1;

  logic          clk;
  logic          arst_n;
  op0_t [NJ-1:0] left_data;
  logic [NJ-1:0] left_valid;
  logic [NJ-1:0] left_ready;
  logic [NJ-1:0] left_last;
  op0_t [NJ-1:0] right_data;
  logic [NJ-1:0] right_valid;
  logic [NJ-1:0] right_ready;
  logic [NJ-1:0] right_last;
  op1_t          top_data;
  logic          top_valid;
  logic          top_ready;
  logic          top_last;
  op1_t          bottom_data;
  logic          bottom_valid;
  logic          bottom_ready;
  logic          bottom_last;
  psum_t         result_data;
  logic          result_valid;
  logic          result_ready;
  logic          result_last;
  logic          err_unaligned_data;

  logic [31:0] lfsr_state;

  // Vectors of the current round
  int    k_len;
  op1_t  top_w [MAX_K];
  logic  top_l [MAX_K];
  op0_t  left_w [NJ][MAX_K];
  logic  left_l [NJ][MAX_K];
  psum_t exp_res [NJ];

  // Words sent and words seen
  int            top_in;
  int            left_in [NJ];
  int            bot_out;
  int            right_out [NJ];
  int            res_out;
  logic          top_xfer;
  logic [NJ-1:0] left_xfer;
  logic          full_ready;
  logic          compare_en;

  tb_clock_gen i_clk (
    .clk(clk)
  );

  pe_column #(
    .PE_NUMBER_J(NJ)
  ) i_dut (
    .clk               (clk),
    .arst_n            (arst_n),
    .left_data         (left_data),
    .left_valid        (left_valid),
    .left_ready        (left_ready),
    .left_last         (left_last),
    .right_data        (right_data),
    .right_valid       (right_valid),
    .right_ready       (right_ready),
    .right_last        (right_last),
    .top_data          (top_data),
    .top_valid         (top_valid),
    .top_ready         (top_ready),
    .top_last          (top_last),
    .bottom_data       (bottom_data),
    .bottom_valid      (bottom_valid),
    .bottom_ready      (bottom_ready),
    .bottom_last       (bottom_last),
    .result_data       (result_data),
    .result_valid      (result_valid),
    .result_ready      (result_ready),
    .result_last       (result_last),
    .err_unaligned_data(err_unaligned_data)
  );

  task automatic report_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped after a failing check");
  endtask

  task automatic check_psum(input string name, input psum_t got, input psum_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_op0(input string name, input op0_t got, input op0_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_op1(input string name, input op1_t got, input op1_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      report_failure();
    end
  endtask

  // Galois form stepped once per bit
  function automatic logic lfsr_step();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (out_bit ? 32'h8020_0003 : 32'h0);
    return out_bit;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr_step()};
    end
    return value;
  endfunction

  // Most negative value one time in eight
  function automatic logic [15:0] pick_operand();
    logic [31:0] r;
    r = rand_bits(3);
    if (r[2:0] == 3'd0) begin
      return 16'h8000;
    end
    r = rand_bits(16);
    return r[15:0];
  endfunction

  // Exact dot product wrapped to the sum width
  function automatic psum_t dot_product(input int row);
    longint sum;
    sum = 0;
    for (int k = 0; k < k_len; k++) begin
      sum += longint'(left_w[row][k]) * longint'(top_w[k]);
    end
    return sum[PSUM_WIDTH-1:0];
  endfunction

  function automatic logic round_done();
    logic done;
    done = (res_out == NJ) && (bot_out == k_len) && (top_in == k_len);
    for (int j = 0; j < NJ; j++) begin
      done = done && (right_out[j] == k_len) && (left_in[j] == k_len);
    end
    return done;
  endfunction

  task automatic build_round(input int len);
    k_len = len;
    for (int k = 0; k < len; k++) begin
      top_w[k] = pick_operand();
      top_l[k] = (k == len - 1);
      for (int j = 0; j < NJ; j++) begin
        left_w[j][k] = pick_operand();
        left_l[j][k] = (k == len - 1);
      end
    end
  endtask

  task automatic build_const_round(input int len, input logic [15:0] a, input logic [15:0] b);
    k_len = len;
    for (int k = 0; k < len; k++) begin
      top_w[k] = b;
      top_l[k] = (k == len - 1);
      for (int j = 0; j < NJ; j++) begin
        left_w[j][k] = a;
        left_l[j][k] = (k == len - 1);
      end
    end
  endtask

  // Expected sums and fresh counters
  // Transfer flags carry over so a held word is still released
  task automatic start_round();
    top_in  = 0;
    bot_out = 0;
    res_out = 0;
    for (int j = 0; j < NJ; j++) begin
      exp_res[j]   = dot_product(j);
      left_in[j]   = 0;
      right_out[j] = 0;
    end
  endtask

  // Transfers are known once inputs settle after the falling edge
  task automatic sample_cycle();
    top_xfer = top_valid & top_ready;
    if (top_xfer) begin
      top_in++;
    end
    for (int j = 0; j < NJ; j++) begin
      left_xfer[j] = left_valid[j] & left_ready[j];
      if (left_xfer[j]) begin
        left_in[j]++;
      end
    end
    if (compare_en) begin
      if (bottom_valid && bottom_ready) begin
        if (bot_out >= k_len) begin
          $display("Bottom stream passed on more words than the top vector holds");
          report_failure();
        end
        check_op1("bottom_data", bottom_data, top_w[bot_out]);
        check_bit("bottom_last", bottom_last, top_l[bot_out]);
        bot_out++;
      end
      for (int j = 0; j < NJ; j++) begin
        if (right_valid[j] && right_ready[j]) begin
          if (right_out[j] >= k_len) begin
            $display("Row %0d passed on more words than its left vector holds", j);
            report_failure();
          end
          check_op0($sformatf("right_data[%0d]", j), right_data[j], left_w[j][right_out[j]]);
          check_bit($sformatf("right_last[%0d]", j), right_last[j], left_l[j][right_out[j]]);
          right_out[j]++;
        end
      end
      if (result_valid && result_ready) begin
        if (res_out >= NJ) begin
          $display("Column emitted more results than it has rows");
          report_failure();
        end
        check_psum("result_data", result_data, exp_res[res_out]);
        check_bit("result_last", result_last, res_out == NJ - 1);
        res_out++;
      end
    end
  endtask

  task automatic drive_cycle();
    logic [31:0] r;
    @(negedge clk);
    // New top word only once the old one is gone
    if (!top_valid || top_xfer) begin
      r = rand_bits(2);
      if (top_in < k_len && r[1:0] != 2'b00) begin
        top_valid = 1'b1;
        top_data  = top_w[top_in];
        top_last  = top_l[top_in];
      end else begin
        top_valid = 1'b0;
      end
    end
    for (int j = 0; j < NJ; j++) begin
      if (!left_valid[j] || left_xfer[j]) begin
        r = rand_bits(2);
        if (left_in[j] < k_len && r[1:0] != 2'b00) begin
          left_valid[j] = 1'b1;
          left_data[j]  = left_w[j][left_in[j]];
          left_last[j]  = left_l[j][left_in[j]];
        end else begin
          left_valid[j] = 1'b0;
        end
      end
    end
    // Output back-pressure
    if (full_ready) begin
      right_ready  = '1;
      bottom_ready = 1'b1;
      result_ready = 1'b1;
    end else begin
      r = rand_bits(NJ + 2);
      right_ready  = r[NJ-1:0];
      bottom_ready = r[NJ];
      result_ready = r[NJ+1];
    end
    #1;
    sample_cycle();
  endtask

  task automatic run_round(input int round_no);
    int cycles;
    cycles = 0;
    start_round();
    while (!round_done()) begin
      if (cycles >= ROUND_TIMEOUT) begin
        $display("Round %0d did not deliver all of its outputs in %0d cycles",
                 round_no, ROUND_TIMEOUT);
        report_failure();
      end
      drive_cycle();
      cycles++;
    end
    check_bit("err_unaligned_data", err_unaligned_data, 1'b0);
  endtask

  task automatic apply_reset();
    @(negedge clk);
    arst_n       = 1'b0;
    top_valid    = 1'b0;
    left_valid   = '0;
    // Consumers stay ready through reset
    right_ready  = '1;
    bottom_ready = 1'b1;
    result_ready = 1'b1;
    top_xfer     = 1'b0;
    left_xfer    = '0;
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    #1;
    // Idle outputs and open inputs
    check_bit("result_valid", result_valid, 1'b0);
    check_bit("bottom_valid", bottom_valid, 1'b0);
    check_bit("top_ready", top_ready, 1'b1);
    check_bit("err_unaligned_data", err_unaligned_data, 1'b0);
    for (int j = 0; j < NJ; j++) begin
      check_bit($sformatf("right_valid[%0d]", j), right_valid[j], 1'b0);
      check_bit($sformatf("left_ready[%0d]", j), left_ready[j], 1'b1);
    end
  endtask

  // Extra last on one row at the first pair
  task automatic run_error_round();
    int cycles;
    build_round(4);
    left_l[ERR_ROW][0] = 1'b1;
    start_round();
    compare_en = 1'b0;
    full_ready = 1'b1;
    cycles     = 0;
    while (!err_unaligned_data) begin
      if (cycles >= ERR_TIMEOUT) begin
        $display("err_unaligned_data did not rise after a misaligned pair");
        report_failure();
      end
      drive_cycle();
      cycles++;
    end
    // Must stay up while traffic goes on
    repeat (20) begin
      drive_cycle();
      check_bit("err_unaligned_data", err_unaligned_data, 1'b1);
    end
    compare_en = 1'b1;
    full_ready = 1'b0;
    apply_reset();
  endtask

  initial begin
    lfsr_state   = 32'h72df3dde;
    arst_n       = 1'b0;
    left_data    = '0;
    left_valid   = '0;
    left_last    = '0;
    right_ready  = '0;
    top_data     = '0;
    top_valid    = 1'b0;
    top_last     = 1'b0;
    bottom_ready = 1'b0;
    result_ready = 1'b0;
    top_xfer     = 1'b0;
    left_xfer    = '0;
    full_ready   = 1'b0;
    compare_en   = 1'b1;
    k_len        = 0;
    apply_reset();

    // Extreme operands in single pair and wrapping rounds
    build_const_round(1, 16'h8000, 16'h8000);
    run_round(0);
    build_const_round(8, 16'h8000, 16'h8000);
    run_round(1);
    build_const_round(8, 16'h7fff, 16'h8000);
    run_round(2);

    for (int i = 0; i < RANDOM_ROUNDS; i++) begin
      build_round(int'(rand_bits(3)) + 1);
      run_round(i + 3);
    end

    run_error_round();

    // Normal traffic after the flag was cleared
    for (int i = 0; i < 5; i++) begin
      build_round(int'(rand_bits(3)) + 1);
      run_round(RANDOM_ROUNDS + 3 + i);
    end

    if (i_dut.i_sva.assert_fail_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      report_failure();
    end
  end

endmodule

//--- sim.f
source/mm_pkg.sv
source/axis_skid_buffer.sv
source/pe_control.sv
source/pe_mac.sv
source/linear_pe.sv
source/pe_column.sv
test/tb_clock_gen.sv
test/pe_column_sva.sv
test/tb_pe_column.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pe_column -f sim.f --Mdir obj_dir -o sim_pe_column

# Keep running past assertion errors so the testbench gives the verdict
./obj_dir/sim_pe_column +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
